/* build.f */
+incdir+source
source/rv_pipe_pkg.sv
source/mem_access.sv
source/mem_wb.sv
source/regfile.sv
source/mem_stage_top.sv
verif/tb_clkgen.sv
verif/tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# Compile the memory back end and its testbench with Verilator, run, grade the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_mem_stage -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed, see $LOG"; exit 1; }

cat "$LOG"

grep -qx "Simulation finished: PASS" "$LOG" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

/* verif/tb_mem_stage.sv */
// Testbench for the RV32I memory back end: APB memory model, reference model and checks
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module tb_mem_stage;
    import rv_pipe_pkg::*;

    localparam logic [31:0] SEED       = 32'he9f76e4b;
    localparam int          N_INSTR    = 400;
    localparam int          N_ALU      = 40;    // Leading ALU-only block
    localparam int          TIMEOUT_NS = N_INSTR * 20 * 4 + 2000;

    logic                   clk;
    logic                   rst;
    ex_mem_t                exmem;
    logic                   stall;
    apb_req_t               apb_req;
    apb_rsp_t               apb_rsp;
    logic                   wb_stall;
    mem_wb_t                wb;
    logic [`RV_REG_AW-1:0]  rs1_addr;
    logic [`RV_REG_AW-1:0]  rs2_addr;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;

    logic [31:0]    mem [256];          // APB slave storage
    logic [31:0]    shadow_mem [256];   // Expected memory after each sent store
    logic [31:0]    shadow_regs [32];
    mem_wb_t        exp_q [$];          // Expected retires, oldest first
    apb_req_t       exp_apb;            // Request expected for the last memory op
    apb_req_t       setup_req;          // Request seen in SETUP
    mem_state_e     exp_state = MS_IDLE;    // Expected bus phase
    mem_wb_t        wb_prev;
    logic           held_prev = 1'b0;
    logic           reset_seen = 1'b0;
    logic           stall_en;
    logic           in_access;
    logic [1:0]     wait_left;
    logic [7:0]     slave_idx;
    logic [31:0]    stim_rng;
    logic [31:0]    stall_rng;
    logic [31:0]    slave_rng;
    int             errors = 0;
    int             checks = 0;
    int             retired = 0;

    tb_clkgen i_tb_clkgen (
        .clk_o (clk),
        .rst_o (rst)
    );

    mem_stage_top i_mem_stage_top (
        .clk        (clk),
        .rst_i      (rst),
        .exmem_i    (exmem),
        .stall_o    (stall),
        .apb_req_o  (apb_req),
        .apb_rsp_i  (apb_rsp),
        .wb_stall_i (wb_stall),
        .wb_o       (wb),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // ************************************************************************
    // Helpers and reference model
    // ************************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // Initial memory content, mixes every address bit
    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5A5A_0000 ^ (32'(idx) * 32'h9E37_79B1);
    endfunction

    // Byte lanes covered by the access, starting at the offset
    function automatic logic [3:0] strobe_for(input mem_op_e op, input logic [1:0] off);
        int         size;
        logic [3:0] strb;
        case (op)
            MEM_SB:  size = 1;
            MEM_SH:  size = 2;
            MEM_SW:  size = 4;
            default: size = 0;
        endcase
        for (int i = 0; i < 4; i++) begin
            strb[i] = (i >= int'(off)) && (i < int'(off) + size);
        end
        return strb;
    endfunction

    // Loads from shadow memory with extension, everything else passes alu_result
    function automatic logic [31:0] ref_result(input mem_op_e op, input logic [31:0] addr);
        logic [31:0] lane;
        lane = shadow_mem[addr[9:2]] >> {addr[1:0], 3'b000};
        case (op)
            MEM_LB:  return 32'($signed(lane[7:0]));
            MEM_LBU: return 32'(lane[7:0]);
            MEM_LH:  return 32'($signed(lane[15:0]));
            MEM_LHU: return 32'(lane[15:0]);
            MEM_LW:  return lane;
            default: return addr;
        endcase
    endfunction

    // Read port value, same-cycle write forwarded
    function automatic logic [31:0] expected_read(input logic [4:0] addr, input logic wr_en,
                                                  input mem_wb_t want);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wr_en && (addr == want.rd_addr)) begin
            return want.rd_data;
        end
        return shadow_regs[addr];
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    function automatic ex_mem_t make_bundle(input int seq, input logic alu_only);
        ex_mem_t     b;
        logic [31:0] r;
        logic [1:0]  off;
        r = stim_rand();
        b.valid      = 1'b1;
        b.inst       = stim_rand();
        b.instaddr   = 32'h0000_1000 + 32'(seq) * 32'd4;
        b.mem_op     = alu_only ? MEM_NONE : mem_op_e'(4'(r % 32'd9));
        b.store_data = stim_rand();
        b.rd_addr    = r[8:4];
        b.regs_wen   = (r[11:9] != 3'd0);
        // Naturally aligned offsets only
        off = r[13:12];
        case (b.mem_op)
            MEM_LH, MEM_LHU, MEM_SH: off[0] = 1'b0;
            MEM_LW, MEM_SW:          off = 2'b00;
            default: ;
        endcase
        // 32 words so loads often hit earlier stores
        b.alu_result = (b.mem_op == MEM_NONE) ? stim_rand() : {25'd0, r[18:14], off};
        if (alu_only && (seq % 8 == 0)) begin
            // Writes aimed at x0
            b.rd_addr  = 5'd0;
            b.regs_wen = 1'b1;
        end
        return b;
    endfunction

    // Expected retire, APB request and memory effect of an accepted bundle
    task automatic record_sent(input ex_mem_t b);
        mem_wb_t     want;
        logic [3:0]  strb;
        logic [31:0] wdata;
        int          lane;
        strb = strobe_for(b.mem_op, b.alu_result[1:0]);
        // Store byte k lands in lane offset + k
        for (int i = 0; i < 4; i++) begin
            lane = i - int'(b.alu_result[1:0]);
            wdata[8*i +: 8] = (lane >= 0) ? b.store_data[8*lane +: 8] : 8'h00;
        end
        want.valid    = 1'b1;
        want.inst     = b.inst;
        want.instaddr = b.instaddr;
        want.regs_wen = b.regs_wen;
        want.rd_addr  = b.rd_addr;
        want.rd_data  = ref_result(b.mem_op, b.alu_result);
        exp_q.push_back(want);
        exp_apb.paddr  = {b.alu_result[31:2], 2'b00};
        exp_apb.pwrite = (strb != 4'b0000);
        exp_apb.pstrb  = strb;
        exp_apb.pwdata = wdata;
        // Loads and stores open a transfer in the cycle after acceptance
        if (b.mem_op != MEM_NONE) begin
            exp_state = MS_SETUP;
        end
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                shadow_mem[b.alu_result[9:2]][8*i +: 8] = wdata[8*i +: 8];
            end
        end
    endtask

    // Hold the bundle until an edge with stall low
    task automatic send_bundle(input ex_mem_t b);
        logic taken;
        exmem = b;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            #1;
        end
        record_sent(b);
    endtask

    initial begin
        exmem    = '0;
        stall_en = 1'b0;
        stim_rng = SEED;
        for (int i = 0; i < 256; i++) begin
            shadow_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = 32'd0;
        end
        @(negedge rst);
        @(negedge clk);
        stall_en = 1'b1;
        @(posedge clk);
        #1;
        for (int n = 0; n < N_INSTR; n++) begin
            send_bundle(make_bundle(n, n < N_ALU));
            if (stim_rand() % 32'd8 == 32'd0) begin
                // Idle cycle
                exmem.valid = 1'b0;
                @(posedge clk);
                #1;
            end
        end
        exmem.valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Drain window for stray retires
        repeat (8) @(posedge clk);
        $display("checks %0d, errors %0d, retired %0d of %0d", checks, errors, retired, N_INSTR);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Write-back stall and read addresses, rs1 follows the MEM/WB destination
    initial begin
        wb_stall  = 1'b0;
        rs1_addr  = '0;
        rs2_addr  = '0;
        stall_rng = xorshift32(SEED ^ 32'h0000_00ff);
        forever begin
            @(posedge clk);
            #1;
            stall_rng = xorshift32(stall_rng);
            wb_stall  = stall_en && (stall_rng[1:0] == 2'b00);
            rs1_addr  = wb.rd_addr;
            rs2_addr  = rs2_addr + 5'd1;
        end
    end

    // ************************************************************************
    // APB memory model, 0 to 3 wait states per transfer
    // ************************************************************************

    initial begin
        apb_rsp   = '0;
        in_access = 1'b0;
        wait_left = 2'd0;
        slave_rng = SEED;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(posedge clk);
            #1;
            slave_idx = apb_req.paddr[9:2];
            if (apb_req.psel && apb_req.penable) begin
                if (!in_access) begin
                    slave_rng = xorshift32(slave_rng);
                    wait_left = slave_rng[1:0];
                    in_access = 1'b1;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
                apb_rsp.pready = (wait_left == 2'd0);
                // Junk until the data phase ends
                apb_rsp.prdata = ~mem[slave_idx];
                if (apb_rsp.pready && apb_req.pwrite) begin
                    for (int i = 0; i < 4; i++) begin
                        if (apb_req.pstrb[i]) begin
                            mem[slave_idx][8*i +: 8] = apb_req.pwdata[8*i +: 8];
                        end
                    end
                end else if (apb_rsp.pready) begin
                    apb_rsp.prdata = mem[slave_idx];
                end
            end else begin
                in_access      = 1'b0;
                apb_rsp.pready = 1'b0;
            end
        end
    end

    // ************************************************************************
    // Compare, sampled mid-cycle for the coming edge
    // ************************************************************************

    task automatic monitor_cycle();
        mem_wb_t     want;
        logic        wr_en;
        logic [31:0] wmask;
        want  = '0;
        wr_en = 1'b0;
        if (wb.valid && !wb_stall) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("An instruction retired that was never sent, at %0t ns", $time);
            end else begin
                want = exp_q.pop_front();
                compare_value("retire inst", wb.inst, want.inst);
                compare_value("retire instaddr", wb.instaddr, want.instaddr);
                compare_value("retire rd_addr", 32'(wb.rd_addr), 32'(want.rd_addr));
                compare_value("retire regs_wen", 32'(wb.regs_wen), 32'(want.regs_wen));
                compare_value("retire rd_data", wb.rd_data, want.rd_data);
                wr_en = want.regs_wen && (want.rd_addr != 5'd0);
                retired++;
            end
        end
        compare_value("rs1 read", rs1_data, expected_read(rs1_addr, wr_en, want));
        compare_value("rs2 read", rs2_data, expected_read(rs2_addr, wr_en, want));
        if (wr_en) begin
            shadow_regs[want.rd_addr] = want.rd_data;
        end
        // MEM/WB frozen across a stalled edge
        if (held_prev) begin
            compare_value("held inst", wb.inst, wb_prev.inst);
            compare_value("held instaddr", wb.instaddr, wb_prev.instaddr);
            compare_value("held rd_data", wb.rd_data, wb_prev.rd_data);
            compare_value("held flags", 32'({wb.valid, wb.regs_wen, wb.rd_addr}),
                          32'({wb_prev.valid, wb_prev.regs_wen, wb_prev.rd_addr}));
        end
        wb_prev   = wb;
        held_prev = wb_stall;
        // Busy from acceptance through the pready edge
        compare_value("stall_o", 32'(stall), 32'(wb_stall || (exp_state != MS_IDLE)));
        compare_value("psel", 32'(apb_req.psel), 32'(exp_state != MS_IDLE));
        compare_value("penable", 32'(apb_req.penable), 32'(exp_state == MS_ACCESS));
        if (exp_state == MS_SETUP) begin
            setup_req = apb_req;
            for (int i = 0; i < 4; i++) begin
                wmask[8*i +: 8] = {8{exp_apb.pstrb[i]}};
            end
            compare_value("paddr", apb_req.paddr, exp_apb.paddr);
            compare_value("pwrite", 32'(apb_req.pwrite), 32'(exp_apb.pwrite));
            compare_value("pstrb", 32'(apb_req.pstrb), 32'(exp_apb.pstrb));
            compare_value("pwdata lanes", apb_req.pwdata & wmask, exp_apb.pwdata & wmask);
            exp_state = MS_ACCESS;
        end else if (exp_state == MS_ACCESS) begin
            // ACCESS keeps the SETUP request
            compare_value("ACCESS paddr", apb_req.paddr, setup_req.paddr);
            compare_value("ACCESS pwdata", apb_req.pwdata, setup_req.pwdata);
            compare_value("ACCESS pstrb/pwrite", 32'({apb_req.pwrite, apb_req.pstrb}),
                          32'({setup_req.pwrite, setup_req.pstrb}));
            // Transfer ends at the edge that samples pready
            if (apb_rsp.pready) begin
                exp_state = MS_IDLE;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!reset_seen) begin
                // State right after reset
                compare_value("reset wb valid", 32'(wb.valid), 32'd0);
                compare_value("reset wb regs_wen", 32'(wb.regs_wen), 32'd0);
                compare_value("reset wb inst", wb.inst, `RV_INST_NOP);
                compare_value("reset psel", 32'(apb_req.psel), 32'd0);
                compare_value("reset stall_o", 32'(stall), 32'd0);
                compare_value("reset rs1", rs1_data, 32'd0);
                compare_value("reset rs2", rs2_data, 32'd0);
                reset_seen = 1'b1;
            end
            monitor_cycle();
        end
    end

    // Watchdog, 20 cycles per instruction plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("Run did not complete within %0d ns, %0d retires still expected",
                 TIMEOUT_NS, exp_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
// Testbench clock and power-on reset source for the memory back end
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset high for RST_CYCLES rising edges, released just after the last one
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* source/mem_stage_top.sv */
// Back-end top: memory stage, MEM/WB register and register file
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module mem_stage_top (
    input  wire                     clk,
    input  wire                     rst_i,
    // Execute side
    input  wire rv_pipe_pkg::ex_mem_t exmem_i,
    output logic                    stall_o,
    // APB data memory
    output rv_pipe_pkg::apb_req_t   apb_req_o,
    input  wire rv_pipe_pkg::apb_rsp_t apb_rsp_i,
    // Write-back
    input  wire                     wb_stall_i,
    output rv_pipe_pkg::mem_wb_t    wb_o,
    // Decode read ports
    input  wire [`RV_REG_AW-1:0]    rs1_addr_i,
    input  wire [`RV_REG_AW-1:0]    rs2_addr_i,
    output logic [`RV_XLEN-1:0]     rs1_data_o,
    output logic [`RV_XLEN-1:0]     rs2_data_o
);
    import rv_pipe_pkg::*;

    // ************************************************************************
    // Internal nets
    // ************************************************************************

    mem_wb_t    mem_result;     // Memory stage result or bubble
    logic       mem_hold;       // Memory stage busy
    mem_wb_t    wb_data;        // MEM/WB content
    logic       rf_wen;

    assign stall_o = mem_hold;
    assign wb_o    = wb_data;

    // Retire only on a valid, unstalled write-back
    assign rf_wen = wb_data.valid && wb_data.regs_wen && !wb_stall_i;

    // ************************************************************************
    // Instances
    // ************************************************************************

    mem_access i_mem_access (
        .clk          (clk),
        .rst_i        (rst_i),
        .exmem_i      (exmem_i),
        .wb_stall_i   (wb_stall_i),
        .apb_rsp_i    (apb_rsp_i),
        .apb_req_o    (apb_req_o),
        .stall_o      (mem_hold),
        .mem_result_o (mem_result)
    );

    // Held while write-back is stalled
    mem_wb i_mem_wb (
        .clk    (clk),
        .rst_i  (rst_i),
        .lden_i (!wb_stall_i),
        .mem_i  (mem_result),
        .wb_o   (wb_data)
    );

    regfile i_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .wen_i    (rf_wen),
        .waddr_i  (wb_data.rd_addr),
        .wdata_i  (wb_data.rd_data),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

endmodule

`default_nettype wire

/* source/regfile.sv */
// Register file: 32 x XLEN, x0 tied to zero, one write port, two bypassed reads
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module regfile (
    input  wire                     clk,
    input  wire                     rst_i,
    // Write port from MEM/WB
    input  wire                     wen_i,
    input  wire [`RV_REG_AW-1:0]    waddr_i,
    input  wire [`RV_XLEN-1:0]      wdata_i,
    // Read ports to decode
    input  wire [`RV_REG_AW-1:0]    raddr1_i,
    input  wire [`RV_REG_AW-1:0]    raddr2_i,
    output logic [`RV_XLEN-1:0]     rdata1_o,
    output logic [`RV_XLEN-1:0]     rdata2_o
);

    logic [`RV_XLEN-1:0] regs_q [`RV_REG_NUM];

    // ************************************************************************
    // Write port
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            // x0 never written
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // ************************************************************************
    // Read ports
    // ************************************************************************

    // Same-cycle write forwarded to the reader
    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic [`RV_REG_AW-1:0] raddr,
        input logic [`RV_XLEN-1:0]   stored
    );
        if (raddr == '0) begin
            return '0;
        end
        if (wen_i && (waddr_i == raddr)) begin
            return wdata_i;
        end
        return stored;
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i, regs_q[raddr1_i]);
    end

    always_comb begin
        rdata2_o = read_port(raddr2_i, regs_q[raddr2_i]);
    end

endmodule

`default_nettype wire

/* source/mem_wb.sv */
// MEM/WB pipeline register with load enable, resets to a NOP bubble
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module mem_wb (
    input  wire                     clk,
    input  wire                     rst_i,
    // Load enable, low under write-back stall
    input  wire                     lden_i,
    // From memory stage
    input  wire rv_pipe_pkg::mem_wb_t mem_i,
    // To write-back and register file
    output rv_pipe_pkg::mem_wb_t    wb_o
);
    import rv_pipe_pkg::*;

    mem_wb_t wb_q;

    // ************************************************************************
    // Staged fields
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // NOP bubble
            wb_q.valid    <= 1'b0;
            wb_q.inst     <= `RV_INST_NOP;
            wb_q.instaddr <= '0;
            wb_q.regs_wen <= 1'b0;
            wb_q.rd_addr  <= '0;
            wb_q.rd_data  <= '0;
        end else if (lden_i) begin
            // Instruction and its address
            wb_q.valid    <= mem_i.valid;
            wb_q.inst     <= mem_i.inst;
            wb_q.instaddr <= mem_i.instaddr;
            // Register write
            wb_q.regs_wen <= mem_i.regs_wen;
            wb_q.rd_addr  <= mem_i.rd_addr;
            wb_q.rd_data  <= mem_i.rd_data;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

/* source/mem_access.sv */
// Memory-access stage: APB master for loads and stores, lane alignment, load extension
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_defines.svh"

module mem_access (
    input  wire                     clk,
    input  wire                     rst_i,
    // From execute
    input  wire rv_pipe_pkg::ex_mem_t exmem_i,
    input  wire                     wb_stall_i,
    // APB master
    input  wire rv_pipe_pkg::apb_rsp_t apb_rsp_i,
    output rv_pipe_pkg::apb_req_t   apb_req_o,
    // Back-pressure to execute
    output logic                    stall_o,
    // To MEM/WB
    output rv_pipe_pkg::mem_wb_t    mem_result_o
);
    import rv_pipe_pkg::*;

    // ************************************************************************
    // Declarations
    // ************************************************************************

    mem_state_e             state_q;
    mem_state_e             state_d;
    ex_mem_t                req_q;      // Captured bundle
    logic [`RV_XLEN-1:0]    load_q;     // Load result parked under wb stall
    logic [1:0]             byte_off;
    logic [`RV_XLEN-1:0]    lane_data;
    logic [`RV_XLEN-1:0]    load_ext;
    logic [`RV_XLEN-1:0]    rd_src;
    logic                   req_load;
    logic                   req_store;
    logic                   accept;
    logic                   xfer_done;

    function automatic logic is_load(input mem_op_e op);
        return (op == MEM_LB) || (op == MEM_LH) || (op == MEM_LW) ||
               (op == MEM_LBU) || (op == MEM_LHU);
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
    endfunction

    // ************************************************************************
    // Handshake and FSM
    // ************************************************************************

    // Busy while a transfer runs or write-back is held
    assign stall_o   = wb_stall_i || (state_q != MS_IDLE);
    assign accept    = !stall_o;
    assign xfer_done = (state_q == MS_ACCESS) && apb_rsp_i.pready;

    assign req_load  = is_load(req_q.mem_op);
    assign req_store = is_store(req_q.mem_op);
    assign byte_off  = req_q.alu_result[1:0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                // Only loads and stores go to the bus
                if (accept && exmem_i.valid &&
                    (is_load(exmem_i.mem_op) || is_store(exmem_i.mem_op))) begin
                    state_d = MS_SETUP;
                end
            end
            MS_SETUP: begin
                state_d = MS_ACCESS;
            end
            MS_ACCESS: begin
                // Wait states until pready
                if (apb_rsp_i.pready) begin
                    state_d = MS_IDLE;
                end
            end
            default: begin
                state_d = MS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= MS_IDLE;
            req_q.valid <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                req_q <= exmem_i;
            end else if (xfer_done && !wb_stall_i) begin
                // Retired straight into MEM/WB at this edge
                req_q.valid <= 1'b0;
            end
        end
    end

    // Completed load data, used when the retire is delayed
    always_ff @(posedge clk) begin
        if (xfer_done) begin
            load_q <= load_ext;
        end
    end

    // ************************************************************************
    // APB request
    // ************************************************************************

    always_comb begin
        apb_req_o.psel    = (state_q != MS_IDLE);
        apb_req_o.penable = (state_q == MS_ACCESS);
        apb_req_o.pwrite  = req_store;
        // Word address, lane from low bits
        apb_req_o.paddr   = {req_q.alu_result[`RV_ADDR_W-1:2], 2'b00};
        apb_req_o.pwdata  = req_q.store_data << {byte_off, 3'b000};
        case (req_q.mem_op)
            MEM_SB:  apb_req_o.pstrb = 4'b0001 << byte_off;
            MEM_SH:  apb_req_o.pstrb = 4'b0011 << byte_off;
            MEM_SW:  apb_req_o.pstrb = 4'b1111;
            default: apb_req_o.pstrb = 4'b0000;    // reads
        endcase
    end

    // ************************************************************************
    // Load alignment and extension
    // ************************************************************************

    always_comb begin
        lane_data = apb_rsp_i.prdata >> {byte_off, 3'b000};
        case (req_q.mem_op)
            MEM_LB:  load_ext = {{(`RV_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            MEM_LBU: load_ext = {{(`RV_XLEN-8){1'b0}}, lane_data[7:0]};
            MEM_LH:  load_ext = {{(`RV_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            MEM_LHU: load_ext = {{(`RV_XLEN-16){1'b0}}, lane_data[15:0]};
            default: load_ext = lane_data;
        endcase
    end

    // Live bus data on the pready cycle, parked copy afterwards
    assign rd_src = (state_q == MS_ACCESS) ? load_ext : load_q;

    // ************************************************************************
    // Result to MEM/WB
    // ************************************************************************

    always_comb begin
        // Bubble by default
        mem_result_o.valid    = 1'b0;
        mem_result_o.inst     = `RV_INST_NOP;
        mem_result_o.instaddr = '0;
        mem_result_o.regs_wen = 1'b0;
        mem_result_o.rd_addr  = '0;
        mem_result_o.rd_data  = '0;
        if (req_q.valid && ((state_q == MS_IDLE) || xfer_done)) begin
            mem_result_o.valid    = 1'b1;
            mem_result_o.inst     = req_q.inst;
            mem_result_o.instaddr = req_q.instaddr;
            mem_result_o.regs_wen = req_q.regs_wen;
            mem_result_o.rd_addr  = req_q.rd_addr;
            // Stores and ALU ops write back alu_result
            mem_result_o.rd_data  = req_load ? rd_src : req_q.alu_result;
        end
    end

endmodule

`default_nettype wire

/* source/rv_pipe_pkg.sv */
// Pipeline bundle, memory-op and APB types for the RV32I back end
`default_nettype none

`include "rv_core_defines.svh"

package rv_pipe_pkg;

    // ************************************************************************
    // Enumerations
    // ************************************************************************

    // Memory operation carried from execute
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    // APB master states
    typedef enum logic [1:0] {
        MS_IDLE,
        MS_SETUP,
        MS_ACCESS
    } mem_state_e;

    // ************************************************************************
    // Pipeline bundles
    // ************************************************************************

    // Execute to memory stage
    typedef struct packed {
        logic                   valid;
        logic [`RV_INST_W-1:0]  inst;
        logic [`RV_ADDR_W-1:0]  instaddr;
        mem_op_e                mem_op;
        logic [`RV_XLEN-1:0]    alu_result;  // Also the load/store address
        logic [`RV_XLEN-1:0]    store_data;
        logic                   regs_wen;
        logic [`RV_REG_AW-1:0]  rd_addr;
    } ex_mem_t;

    // Memory stage to write-back
    typedef struct packed {
        logic                   valid;
        logic [`RV_INST_W-1:0]  inst;
        logic [`RV_ADDR_W-1:0]  instaddr;
        logic                   regs_wen;
        logic [`RV_REG_AW-1:0]  rd_addr;
        logic [`RV_XLEN-1:0]    rd_data;
    } mem_wb_t;

    // APB master to slave
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`RV_ADDR_W-1:0]  paddr;
        logic [`RV_XLEN-1:0]    pwdata;
        logic [`RV_XLEN/8-1:0]  pstrb;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic                   pready;
        logic [`RV_XLEN-1:0]    prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* source/rv_core_defines.svh */
// RV32I core widths and reset constants shared by the memory back end
// ****************************************************************************
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// ****************************************************************************
// Datapath widths
// ****************************************************************************

// Data and register width
`define RV_XLEN     32

// Instruction word width
`define RV_INST_W   32

// Instruction and data address width
`define RV_ADDR_W   32

// ****************************************************************************
// Register file geometry
// ****************************************************************************

// Register index width
`define RV_REG_AW   5
// Architectural registers, x0 included
`define RV_REG_NUM  32

// addi x0,x0,0 for reset and bubbles
`define RV_INST_NOP 32'h0000_0013

`endif
